/* sim/fpu_cmp_stimulus.txt */
# columns: group clear rm op_a op_b expected_result expected_flags
# rm 0=FLE 1=FLT 2=FEQ, op_a op_b and flags in hex, clear hits the result edge
2 0 1 3FF0000000000000 4000000000000000 1 00
2 0 1 4000000000000000 3FF0000000000000 0 00
2 0 0 3FF0000000000000 3FF0000000000000 1 00
2 0 1 3FF0000000000000 3FF0000000000000 0 00
2 0 2 3FF0000000000000 3FF0000000000000 1 00
2 0 2 3FF0000000000000 3FF8000000000000 0 00
2 0 1 C000000000000000 BFF0000000000000 1 00
2 0 0 BFF0000000000000 C000000000000000 0 00
2 0 0 BFF8000000000000 BFF8000000000000 1 00
2 0 1 BFF0000000000000 3FF0000000000000 1 00
2 0 0 3FF0000000000000 BFF0000000000000 0 00
2 0 1 0000000000000001 0000000000000002 1 00
2 0 1 8000000000000001 0000000000000001 1 00
2 0 0 0000000000000001 3FE0000000000000 1 00
2 0 1 8000000000000001 8000000000000000 1 00
2 0 2 3FF0000000000000 BFF0000000000000 0 00
3 0 2 0000000000000000 8000000000000000 1 00
3 0 1 8000000000000000 0000000000000000 0 00
3 0 0 0000000000000000 8000000000000000 1 00
3 0 1 FFF0000000000000 7FF0000000000000 1 00
3 0 1 7FF0000000000000 FFF0000000000000 0 00
3 0 0 7FF0000000000000 7FF0000000000000 1 00
3 0 2 FFF0000000000000 FFF0000000000000 1 00
3 0 1 FFF0000000000000 FFF0000000000000 0 00
3 0 1 3FF0000000000000 7FF0000000000000 1 00
3 0 0 FFF0000000000000 C000000000000000 1 00
4 0 2 7FF8000000000000 3FF0000000000000 0 00
4 0 2 3FF0000000000000 7FF8000000000000 0 00
4 0 2 7FF8000000000000 7FF8000000000000 0 00
4 0 2 7FF0000000000001 3FF0000000000000 0 10
4 0 1 7FF8000000000000 3FF0000000000000 0 10
4 0 0 3FF0000000000000 7FF0000000000001 0 10
4 0 0 FFF8000000000000 FFF8000000000000 0 10
5 1 2 3FF0000000000000 3FF0000000000000 1 00
5 0 1 7FF8000000000000 0000000000000000 0 10
5 0 2 3FF0000000000000 4000000000000000 0 00
5 0 0 3FF0000000000000 4000000000000000 1 00
5 1 0 7FF0000000000001 0000000000000000 0 10
5 0 1 0000000000000000 3FF0000000000000 1 00
5 1 1 3FF0000000000000 0000000000000000 0 00
5 0 2 0000000000000000 0000000000000000 1 00
6 0 1 3FF0000000000000 4000000000000000 1 00
6 0 0 4000000000000000 3FF0000000000000 0 00
6 0 2 7FF0000000000001 7FF0000000000001 0 10
6 0 2 8000000000000000 0000000000000000 1 00
6 1 1 C000000000000000 FFF0000000000000 0 00
6 0 0 0000000000000002 0000000000000002 1 00
6 0 3 3FF0000000000000 4000000000000000 0 00

/* verilog.f */
src/fpu_cmp_pkg.sv
src/fpu_cmp_unpack.sv
src/fpu_cmp.sv
src/fpu_cmp_flags.sv
src/fpu_cmp_top.sv
sim/tb_fpu_cmp.sv

/* Bender.yml */
package:
  name: fpu_cmp

dependencies: {}

sources:
  # rtl in compile order
  - src/fpu_cmp_pkg.sv
  - src/fpu_cmp_unpack.sv
  - src/fpu_cmp.sv
  - src/fpu_cmp_flags.sv
  - src/fpu_cmp_top.sv

  # testbench
  - target: test
    files:
      - sim/tb_fpu_cmp.sv

/* sim/tb_fpu_cmp.sv */
// ##############################
// testbench for the fpu compare unit
// replays the stimulus file through the DUT and
// checks result, flags, latency and accrued fflags
// ##############################

`timescale 1ns/100ps

module tb_fpu_cmp import fpu_cmp_pkg::*; ();

    localparam int MAX_LINES    = 256;
    localparam int CLK_HALF     = 2;   // 4 ns period
    localparam int RST_CYCLES   = 8;
    localparam int SEED         = 65607;
    localparam int BURST_GROUP  = 6;   // lines issued on consecutive cycles
    localparam int RESULT_DELAY = 2;   // cycles from driving valid_i to valid_o

    typedef struct packed {
        logic [7:0] grp;
        logic       clr;
        fpu_rm_t    rm;
        fp64_t      op_a;
        fp64_t      op_b;
        logic       res;
        fpu_flags_t flags;
    } stim_t;

    typedef struct packed {
        logic [7:0] grp;
        logic       clr;
        logic       res;
        fpu_flags_t flags;
    } expect_t;

    logic        clk;
    logic        rst_n_i;
    logic        valid_i;
    fpu_rm_t     rm_i;
    fp64_t       op_a_i;
    fp64_t       op_b_i;
    logic        fflags_clr_i = 1'b0;
    logic        valid_o;
    logic [63:0] result_o;
    fpu_flags_t  flags_o;
    fpu_flags_t  fflags_o;

    logic        clr_issue;
    logic        clr_idle;
    logic        loaded = 1'b0;
    stim_t       stim_mem [MAX_LINES];
    int          n_lines = 0;
    expect_t     exp_q [$];
    int          issue_q [$];
    expect_t     exp_e;
    int          issue_cyc;
    fpu_flags_t  fflags_model = '0;   // own copy of the accrued flags

    int cyc           = 0;
    int n_checked     = 0;
    int checks        = 0;
    int errors        = 0;
    int grp_err       = 0;
    int cur_grp       = -1;
    int groups_passed = 0;
    int groups_failed = 0;

    fpu_cmp_top u_dut (
        .clk          (clk),
        .rst_n_i      (rst_n_i),
        .valid_i      (valid_i),
        .rm_i         (rm_i),
        .op_a_i       (op_a_i),
        .op_b_i       (op_b_i),
        .fflags_clr_i (fflags_clr_i),
        .valid_o      (valid_o),
        .result_o     (result_o),
        .flags_o      (flags_o),
        .fflags_o     (fflags_o)
    );

    initial begin
        clk = 1'b0;
        forever begin
            #CLK_HALF clk = ~clk;
        end
    end

    // a line's clear travels with its op and lands on the result edge
    // clr_idle gives a lone clear with nothing in flight
    always @(posedge clk) begin
        fflags_clr_i <= (valid_i & clr_issue) | clr_idle;
    end

    task automatic load_stimulus();
        int          fd;
        int          r;
        int          n;
        int          g;
        int          c;
        int          m;
        int          res;
        int          fl;
        logic [63:0] a;
        logic [63:0] b;
        logic [8*256-1:0] line_buf;
        fd = $fopen("sim/fpu_cmp_stimulus.txt", "r");
        if (fd == 0) begin
            $display("cannot open the stimulus file sim/fpu_cmp_stimulus.txt");
            errors++;
        end else begin
            while (!$feof(fd) && n_lines < MAX_LINES) begin
                r = $fgets(line_buf, fd);
                if (r > 0) begin
                    n = $sscanf(line_buf, "%d %d %d %h %h %d %h", g, c, m, a, b, res, fl);
                    if (n == 7) begin   // header and blank lines do not scan
                        stim_mem[n_lines].grp   = g[7:0];
                        stim_mem[n_lines].clr   = c[0];
                        stim_mem[n_lines].rm    = m[RM_W-1:0];
                        stim_mem[n_lines].op_a  = a;
                        stim_mem[n_lines].op_b  = b;
                        stim_mem[n_lines].res   = res[0];
                        stim_mem[n_lines].flags = fl[FLAGS_W-1:0];
                        n_lines++;
                    end
                end
            end
            $fclose(fd);
            if (n_lines == 0) begin
                $display("the stimulus file holds no operations");
                errors++;
            end
        end
    endtask

    task automatic check_value(input string name, input logic [63:0] expected,
                               input logic [63:0] actual);
        checks++;
        if (expected !== actual) begin
            $display("Error: %s expected %h actual %h", name, expected, actual);
            errors++;
            grp_err++;
        end
    endtask

    task automatic report_group(input int g);
        if (grp_err == 0) begin
            $display("group %0d passed", g);
            groups_passed++;
        end else begin
            $display("group %0d failed with %0d errors", g, grp_err);
            groups_failed++;
        end
        grp_err = 0;
    endtask

    // lone clear on an idle edge while the last operands stay registered
    task automatic pulse_idle_clear(input int n_done);
        @(posedge clk);
        valid_i   <= 1'b0;
        clr_issue <= 1'b0;
        wait (n_checked == n_done);
        @(posedge clk);
        clr_idle <= 1'b1;
        @(posedge clk);
        clr_idle <= 1'b0;
        @(posedge clk);   // fflags_o clears here
        @(negedge clk);
        fflags_model = '0;
        check_value("fflags_o", fflags_model, fflags_o);
    endtask

    // one check per result pulse, mid-cycle
    always @(negedge clk) begin
        cyc = cyc + 1;
        if (valid_o) begin
            if (exp_q.size() == 0) begin
                $display("valid_o pulsed with no operation outstanding");
                errors++;
                grp_err++;
            end else begin
                exp_e     = exp_q.pop_front();
                issue_cyc = issue_q.pop_front();
                if (exp_e.grp != cur_grp) begin
                    if (cur_grp >= 0) begin
                        report_group(cur_grp);
                    end
                    cur_grp = exp_e.grp;
                end
                if (cyc != issue_cyc + RESULT_DELAY) begin
                    $display("result %0d arrived %0d cycles after issue instead of %0d",
                             n_checked, cyc - issue_cyc, RESULT_DELAY);
                    errors++;
                    grp_err++;
                end
                if (exp_e.clr) begin
                    fflags_model = '0;
                end
                fflags_model = fflags_model | exp_e.flags;  // new flags survive a clear
                check_value("result_o", {63'd0, exp_e.res}, result_o);
                check_value("flags_o", exp_e.flags, flags_o);
                check_value("fflags_o", fflags_model, fflags_o);
                n_checked++;
            end
        end
        if (valid_i) begin
            issue_q.push_back(cyc);
        end
    end

    initial begin
        int      seed_ret;
        int      gap;
        expect_t next_e;
        rst_n_i   = 1'b0;
        valid_i   = 1'b0;
        rm_i      = '0;
        op_a_i    = '0;
        op_b_i    = '0;
        clr_issue = 1'b0;
        clr_idle  = 1'b0;
        seed_ret  = $urandom(SEED);
        load_stimulus();
        loaded = 1'b1;
        repeat (RST_CYCLES) @(posedge clk);
        rst_n_i <= 1'b1;

        @(negedge clk);   // reset values before the first issue
        check_value("valid_o", 64'd0, {63'd0, valid_o});
        check_value("result_o", 64'd0, result_o);
        check_value("flags_o", 64'd0, {59'd0, flags_o});
        check_value("fflags_o", 64'd0, {59'd0, fflags_o});
        report_group(1);

        for (int i = 0; i < n_lines; i++) begin
            if (i > 0 && stim_mem[i].grp != stim_mem[i-1].grp) begin
                pulse_idle_clear(i);
            end
            if (i > 0 && !(stim_mem[i].grp == BURST_GROUP &&
                           stim_mem[i-1].grp == BURST_GROUP)) begin
                gap = $urandom_range(2, 0);
                repeat (gap) begin
                    @(posedge clk);
                    valid_i   <= 1'b0;
                    clr_issue <= 1'b0;
                end
            end
            @(posedge clk);
            valid_i      <= 1'b1;
            rm_i         <= stim_mem[i].rm;
            op_a_i       <= stim_mem[i].op_a;
            op_b_i       <= stim_mem[i].op_b;
            clr_issue    <= stim_mem[i].clr;
            next_e.grp   = stim_mem[i].grp;
            next_e.clr   = stim_mem[i].clr;
            next_e.res   = stim_mem[i].res;
            next_e.flags = stim_mem[i].flags;
            exp_q.push_back(next_e);
        end
        @(posedge clk);
        valid_i   <= 1'b0;
        clr_issue <= 1'b0;

        wait (n_checked == n_lines);
        repeat (4) @(posedge clk);
        if (cur_grp >= 0) begin
            report_group(cur_grp);
        end
        $display("groups passed %0d, groups failed %0d, checks %0d, errors %0d",
                 groups_passed, groups_failed, checks, errors);
        if (errors == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

    // run length scales with the number of operations
    initial begin
        wait (loaded);
        repeat (n_lines * 4 + 100) @(posedge clk);
        $display("watchdog expired with %0d of %0d results checked", n_checked, n_lines);
        $display("TEST FAILED");
        $finish;
    end

endmodule

/* src/fpu_cmp_top.sv */
// ##############################
// fpu compare unit top
// unpack -> compare -> flags, two cycles from
// issue to result, no back-pressure
// ##############################

`timescale 1ns/100ps

module fpu_cmp_top import fpu_cmp_pkg::*; (
    input  logic        clk,
    input  logic        rst_n_i,
    input  logic        valid_i,
    input  fpu_rm_t     rm_i,
    input  fp64_t       op_a_i,
    input  fp64_t       op_b_i,
    input  logic        fflags_clr_i,
    output logic        valid_o,
    output logic [63:0] result_o,
    output fpu_flags_t  flags_o,
    output fpu_flags_t  fflags_o
);

    fpu_cmp_in_t  cmp_in;   // registered, decoded operation
    fpu_cmp_out_t cmp_out;  // combinational compare result

    fpu_cmp_unpack u_unpack (
        .clk     (clk),
        .rst_n_i (rst_n_i),
        .valid_i (valid_i),
        .rm_i    (rm_i),
        .op_a_i  (op_a_i),
        .op_b_i  (op_b_i),
        .cmp_o   (cmp_in)
    );

    fpu_cmp u_cmp (
        .clk       (clk),
        .rst_n_i   (rst_n_i),
        .fpu_cmp_i (cmp_in),
        .fpu_cmp_o (cmp_out)
    );

    fpu_cmp_flags u_flags (
        .clk          (clk),
        .rst_n_i      (rst_n_i),
        .fflags_clr_i (fflags_clr_i),
        .res_i        (cmp_out),
        .valid_o      (valid_o),
        .result_o     (result_o),
        .flags_o      (flags_o),
        .fflags_o     (fflags_o)
    );

endmodule

/* src/fpu_cmp_flags.sv */
// ##############################
// fpu compare output stage
// result register, output valid pulse and the
// sticky accrued flags (fflags) with clear
// ##############################

`timescale 1ns/100ps

module fpu_cmp_flags import fpu_cmp_pkg::*; (
    input  logic         clk,
    input  logic         rst_n_i,
    input  logic         fflags_clr_i,
    input  fpu_cmp_out_t res_i,
    output logic         valid_o,
    output logic [63:0]  result_o,
    output fpu_flags_t   flags_o,
    output fpu_flags_t   fflags_o
);

    fpu_flags_t new_flags;
    fpu_flags_t kept_flags;

    // only a valid result contributes
    assign new_flags  = res_i.valid ? res_i.flags : '0;
    assign kept_flags = fflags_clr_i ? '0 : fflags_o;

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            valid_o <= 1'b0;
        end else begin
            valid_o <= res_i.valid;
        end
    end

    // result and per-op flags hold until the next valid result
    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            result_o <= '0;
            flags_o  <= '0;
        end else if (res_i.valid) begin
            result_o <= res_i.result;
            flags_o  <= res_i.flags;
        end
    end

    // clear first, then OR in, so new flags survive a same-edge clear
    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            fflags_o <= '0;
        end else begin
            fflags_o <= kept_flags | new_flags;
        end
    end

endmodule

/* src/fpu_cmp.sv */
// ##############################
// fpu compare core
// FLE.D / FLT.D / FEQ.D on decoded operands,
// purely combinational, raises NV on NaN input
// ##############################

`timescale 1ns/100ps

module fpu_cmp import fpu_cmp_pkg::*; (
    input  logic         clk,
    input  logic         rst_n_i,
    input  fpu_cmp_in_t  fpu_cmp_i,
    output fpu_cmp_out_t fpu_cmp_o
);

    fp_ext_t         data1;
    fp_ext_t         data2;
    fpu_rm_t         rm;
    fpu_class_t      class1;
    fpu_class_t      class2;

    logic            any_snan;
    logic            any_nan;
    logic            both_zero;
    logic            sign_diff;
    logic            comp_lt;
    logic            comp_le;
    logic [FP_W-1:0] result;
    fpu_flags_t      flags;

    always_comb begin
        data1  = fpu_cmp_i.data1;
        data2  = fpu_cmp_i.data2;
        rm     = fpu_cmp_i.rm;
        class1 = fpu_cmp_i.class1;
        class2 = fpu_cmp_i.class2;

        any_snan  = class1[CLS_SNAN] | class2[CLS_SNAN];
        any_nan   = any_snan | class1[CLS_QNAN] | class2[CLS_QNAN];
        both_zero = (class1[CLS_NEG_ZERO] | class1[CLS_POS_ZERO]) &
                    (class2[CLS_NEG_ZERO] | class2[CLS_POS_ZERO]);
        sign_diff = data1[EXT_W-1] ^ data2[EXT_W-1];

        // magnitude order, valid as such only when the signs agree
        comp_lt = data1[FP_W-1:0] <  data2[FP_W-1:0];
        comp_le = data1[FP_W-1:0] <= data2[FP_W-1:0];

        result = '0;
        flags  = '0;

        case (rm)
            RM_FEQ: begin
                if (any_snan) begin
                    flags[FLAG_NV] = 1'b1;  // signalling only
                end else if (any_nan) begin
                    result[0] = 1'b0;       // quiet NaN, no flag
                end else if (both_zero || (data1 == data2)) begin
                    result[0] = 1'b1;
                end
            end
            RM_FLT: begin
                if (any_nan) begin
                    flags[FLAG_NV] = 1'b1;
                end else if (both_zero) begin
                    result[0] = 1'b0;  // +0 == -0
                end else if (sign_diff) begin
                    result[0] = data1[EXT_W-1];
                end else if (data1[EXT_W-1]) begin
                    result[0] = ~comp_le;  // negatives, larger magnitude is smaller
                end else begin
                    result[0] = comp_lt;
                end
            end
            RM_FLE: begin
                if (any_nan) begin
                    flags[FLAG_NV] = 1'b1;
                end else if (both_zero) begin
                    result[0] = 1'b1;
                end else if (sign_diff) begin
                    result[0] = data1[EXT_W-1];
                end else if (data1[EXT_W-1]) begin
                    result[0] = ~comp_lt;
                end else begin
                    result[0] = comp_le;
                end
            end
            default: begin
                result = '0;  // unknown code, nothing to do
            end
        endcase

        fpu_cmp_o.valid  = fpu_cmp_i.valid;
        fpu_cmp_o.result = result;
        fpu_cmp_o.flags  = flags;
    end

endmodule

/* src/fpu_cmp_unpack.sv */
// ##############################
// fpu compare input stage
// registers each issued operation, sorts both
// operands into the fclass one-hot encoding and
// builds the sign-extended 65-bit operands
// ##############################

`timescale 1ns/100ps

module fpu_cmp_unpack import fpu_cmp_pkg::*; (
    input  logic        clk,
    input  logic        rst_n_i,
    input  logic        valid_i,
    input  fpu_rm_t     rm_i,
    input  fp64_t       op_a_i,
    input  fp64_t       op_b_i,
    output fpu_cmp_in_t cmp_o
);

    logic       valid_q;
    fpu_rm_t    rm_q;
    fp64_t      op_a_q;
    fp64_t      op_b_q;
    fpu_class_t class_a;
    fpu_class_t class_b;

    // one-hot class of a raw double
    function automatic fpu_class_t classify(input fp64_t x);
        logic             sign;
        logic [EXP_W-1:0] exp;
        logic [MAN_W-1:0] man;
        logic             exp_ones;
        logic             exp_zero;
        logic             man_zero;
        fpu_class_t       cls;
        sign     = x[FP_W-1];
        exp      = x[FP_W-2 -: EXP_W];
        man      = x[MAN_W-1:0];
        exp_ones = &exp;
        exp_zero = ~|exp;
        man_zero = ~|man;
        cls      = '0;
        if (exp_ones && !man_zero) begin
            // quiet NaN has the top mantissa bit set
            if (man[MAN_W-1]) begin
                cls[CLS_QNAN] = 1'b1;
            end else begin
                cls[CLS_SNAN] = 1'b1;
            end
        end else if (exp_ones) begin
            cls[sign ? CLS_NEG_INF : CLS_POS_INF] = 1'b1;
        end else if (exp_zero && man_zero) begin
            cls[sign ? CLS_NEG_ZERO : CLS_POS_ZERO] = 1'b1;
        end else if (exp_zero) begin
            cls[sign ? CLS_NEG_SUB : CLS_POS_SUB] = 1'b1;
        end else begin
            cls[sign ? CLS_NEG_NORM : CLS_POS_NORM] = 1'b1;
        end
        return cls;
    endfunction

    // issue strobe, one per operation
    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            valid_q <= 1'b0;
        end else begin
            valid_q <= valid_i;
        end
    end

    // operands only move on issue
    always_ff @(posedge clk) begin
        if (valid_i) begin
            rm_q   <= rm_i;
            op_a_q <= op_a_i;
            op_b_q <= op_b_i;
        end
    end

    assign class_a = classify(op_a_q);
    assign class_b = classify(op_b_q);

    always_comb begin
        cmp_o.valid  = valid_q;
        cmp_o.data1  = {op_a_q[FP_W-1], op_a_q};  // sign copied on top
        cmp_o.data2  = {op_b_q[FP_W-1], op_b_q};
        cmp_o.rm     = rm_q;
        cmp_o.class1 = class_a;
        cmp_o.class2 = class_b;
    end

endmodule

/* src/fpu_cmp_pkg.sv */
// ##############################
// fpu compare package
// widths, operation codes, fclass bit positions,
// exception flag positions and the stage structs
// shared by the double-precision compare unit
// ##############################

package fpu_cmp_pkg;

    // operand geometry, IEEE-754 binary64
    localparam int FP_W    = 64;
    localparam int EXT_W   = FP_W + 1;   // sign repeated above the operand
    localparam int EXP_W   = 11;
    localparam int MAN_W   = 52;

    localparam int RM_W    = 3;
    localparam int CLS_W   = 10;
    localparam int FLAGS_W = 5;

    typedef logic [FP_W-1:0]    fp64_t;
    typedef logic [EXT_W-1:0]   fp_ext_t;
    typedef logic [RM_W-1:0]    fpu_rm_t;
    typedef logic [CLS_W-1:0]   fpu_class_t;
    typedef logic [FLAGS_W-1:0] fpu_flags_t;

    // operation codes, anything else is a no-op
    localparam fpu_rm_t RM_FLE = 3'd0;
    localparam fpu_rm_t RM_FLT = 3'd1;
    localparam fpu_rm_t RM_FEQ = 3'd2;

    // one-hot class positions, RISC-V fclass layout
    localparam int CLS_NEG_INF  = 0;
    localparam int CLS_NEG_NORM = 1;
    localparam int CLS_NEG_SUB  = 2;
    localparam int CLS_NEG_ZERO = 3;
    localparam int CLS_POS_ZERO = 4;
    localparam int CLS_POS_SUB  = 5;
    localparam int CLS_POS_NORM = 6;
    localparam int CLS_POS_INF  = 7;
    localparam int CLS_SNAN     = 8;
    localparam int CLS_QNAN     = 9;

    // flags are NV/DZ/OF/UF/NX from msb down, compare only raises NV
    localparam int FLAG_NV = 4;

    // issued compare with both operands decoded
    typedef struct packed {
        logic       valid;
        fp_ext_t    data1;
        fp_ext_t    data2;
        fpu_rm_t    rm;
        fpu_class_t class1;
        fpu_class_t class2;
    } fpu_cmp_in_t;

    // compare result before the output register
    typedef struct packed {
        logic            valid;
        logic [FP_W-1:0] result;
        fpu_flags_t      flags;
    } fpu_cmp_out_t;

endpackage
